/* source/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Number of buffer entries, kept a power of two so pointers wrap on overflow
`define ROB_DEPTH 16

// Tag width, log2 of ROB_DEPTH
`define ROB_TAG_W 4

// Data and address width
`define XLEN 32

`endif

/* source/rob_pkg.sv */
`default_nettype none

`include "rob_settings.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        CAUSE_DECODE     = 2'd0,
        CAUSE_DIV        = 2'd1,
        CAUSE_LOAD_STORE = 2'd2,
        CAUSE_MISALIGN   = 2'd3
    } exc_cause_e;

    // What the head entry does this cycle
    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_COMMIT,
        ACT_MRET,
        ACT_EXC
    } retire_act_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [4:0]       dest;       // Instruction bits 11 to 7
        logic [2:0]       funct3;
        logic             reg_write;
        logic             mem_write;
        logic             is_mret;
        logic             dec_fault;  // Illegal or undecodable instruction
    } dispatch_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
        logic                  fault;
        exc_cause_e            cause;
    } wb_t;

    typedef struct packed {
        wb_t              wb;
        logic [`XLEN-1:0] addr;  // Store address
    } lsu_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_TAG_W-1:0] tag;
        logic                  mispredict;
        logic [`XLEN-1:0]      link;  // Return address for jal/jalr
    } br_t;

    typedef struct packed {
        logic             busy;
        logic             ready;
        logic             fault;
        exc_cause_e       cause;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] addr;
        logic [4:0]       dest;
        logic [2:0]       funct3;
        logic             reg_write;
        logic             mem_write;
        logic             is_mret;
    } rob_entry_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       dest;
        logic [2:0]       funct3;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] addr;
        logic             reg_write;
        logic             mem_write;
    } commit_t;

endpackage

`default_nettype wire

/* source/rob_storage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module rob_storage import rob_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire dispatch_t             disp,
    input  wire wb_t                   alu_wb,
    input  wire wb_t                   mul_wb,
    input  wire wb_t                   div_wb,
    input  wire lsu_wb_t               lsu_wb,
    input  wire br_t                   br,
    input  wire logic [`ROB_TAG_W:0]   head_ptr,
    input  wire logic                  retire,
    input  wire logic                  flush,
    output logic [`ROB_TAG_W-1:0]      disp_tag,
    output logic                       full,
    output rob_entry_t                 head_entry
);

    localparam int NUM_WB = 4;

    rob_entry_t            entries [`ROB_DEPTH];
    rob_entry_t            new_entry;
    wb_t                   wb_port [NUM_WB];
    logic [`ROB_TAG_W:0]   tail_ptr;     // Extra MSB is the wrap bit
    logic [`ROB_TAG_W:0]   br_tail;
    logic [`ROB_TAG_W-1:0] head_idx;
    logic [`ROB_TAG_W-1:0] br_dist;
    logic [`ROB_TAG_W-1:0] head_off;
    logic                  accept;
    logic                  br_flush;
    logic                  wb_clash;

    // Entry idx sits strictly between the branch and the head, going forward
    function automatic logic is_younger(input logic [`ROB_TAG_W-1:0] idx,
                                        input logic [`ROB_TAG_W-1:0] br_tag,
                                        input logic [`ROB_TAG_W-1:0] hoff);
        logic [`ROB_TAG_W-1:0] off;
        off = idx - br_tag;
        return (off != '0) && ((hoff == '0) || (off < hoff));  // Zero hoff means all the way round
    endfunction

    assign head_idx   = head_ptr[`ROB_TAG_W-1:0];
    assign disp_tag   = tail_ptr[`ROB_TAG_W-1:0];
    assign full       = (tail_ptr[`ROB_TAG_W] != head_ptr[`ROB_TAG_W]) && (disp_tag == head_idx);
    assign accept     = disp.valid && !full;
    assign br_flush   = br.valid && br.mispredict;
    assign head_entry = entries[head_idx];

    // Tail after a mispredict is the slot past the branch, wrap bit rebuilt from head
    assign br_dist  = br.tag - head_idx;
    assign br_tail  = head_ptr + {1'b0, br_dist} + 1'b1;
    assign head_off = head_idx - br.tag;

    always_comb begin
        wb_port[0] = alu_wb;
        wb_port[1] = mul_wb;
        wb_port[2] = div_wb;
        wb_port[3] = lsu_wb.wb;
    end

    always_comb begin
        new_entry           = '0;
        new_entry.busy      = 1'b1;
        new_entry.ready     = disp.dec_fault;  // Nothing to execute, go straight to the head
        new_entry.fault     = disp.dec_fault;
        new_entry.cause     = CAUSE_DECODE;
        new_entry.pc        = disp.pc;
        new_entry.dest      = disp.dest;
        new_entry.funct3    = disp.funct3;
        new_entry.reg_write = disp.reg_write;
        new_entry.mem_write = disp.mem_write;
        new_entry.is_mret   = disp.is_mret;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_ptr <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].busy  <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb_port[p].valid && entries[wb_port[p].tag].busy) begin
                    entries[wb_port[p].tag].ready <= 1'b1;
                    entries[wb_port[p].tag].value <= wb_port[p].value;
                    entries[wb_port[p].tag].fault <= wb_port[p].fault;
                    entries[wb_port[p].tag].cause <= wb_port[p].cause;
                end
            end
            if (lsu_wb.wb.valid && entries[lsu_wb.wb.tag].busy) begin
                entries[lsu_wb.wb.tag].addr <= lsu_wb.addr;
            end
            if (br.valid && entries[br.tag].busy) begin
                entries[br.tag].ready <= 1'b1;
                entries[br.tag].value <= br.link;
            end

            if (accept) begin
                entries[disp_tag] <= new_entry;
                tail_ptr          <= tail_ptr + 1'b1;
            end

            if (retire) begin
                entries[head_idx].busy  <= 1'b0;
                entries[head_idx].ready <= 1'b0;
            end

            // Wrong path entries go, including one dispatched this cycle
            if (br_flush) begin
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    if (is_younger(`ROB_TAG_W'(i), br.tag, head_off)) begin
                        entries[i].busy  <= 1'b0;
                        entries[i].ready <= 1'b0;
                    end
                end
                tail_ptr <= br_tail;
            end

            if (flush) begin  // Exception at head empties the buffer
                tail_ptr <= '0;
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    entries[i].busy  <= 1'b0;
                    entries[i].ready <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        wb_clash = 1'b0;
        for (int a = 0; a < NUM_WB; a++) begin
            if (br.valid && wb_port[a].valid && (wb_port[a].tag == br.tag)) begin
                wb_clash = 1'b1;
            end
            for (int b = a + 1; b < NUM_WB; b++) begin
                if (wb_port[a].valid && wb_port[b].valid && (wb_port[a].tag == wb_port[b].tag)) begin
                    wb_clash = 1'b1;
                end
            end
        end
    end

    // Decode holds its instruction while full, so the tail must not move
    assert property (@(posedge clk) disable iff (rst)
        (disp.valid && full && !br_flush && !flush) |=> (tail_ptr == $past(tail_ptr)))
        else $error("rob_storage: dispatch accepted while full");

    assert property (@(posedge clk) disable iff (rst) !wb_clash)
        else $error("rob_storage: two completion ports name the same tag");

endmodule

`default_nettype wire

/* source/rob_retire.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module rob_retire import rob_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire rob_entry_t         head_entry,
    output logic [`ROB_TAG_W:0]     head_ptr,
    output logic                    retire,
    output logic                    flush,
    output commit_t                 commit,
    output logic                    exc_valid,
    output logic [`XLEN-1:0]        epc,
    output exc_cause_e              exc_cause,
    output logic                    mret_valid
);

    retire_act_e act;

    // Fault wins over mret so a bad mret still traps
    always_comb begin
        act = ACT_NONE;
        if (head_entry.busy && head_entry.ready) begin
            if (head_entry.fault) begin
                act = ACT_EXC;
            end else if (head_entry.is_mret) begin
                act = ACT_MRET;
            end else begin
                act = ACT_COMMIT;
            end
        end
    end

    assign retire = (act == ACT_COMMIT) || (act == ACT_MRET);  // Storage frees the head slot
    assign flush  = (act == ACT_EXC);                          // Storage clears everything

    always_ff @(posedge clk) begin
        if (act == ACT_COMMIT) begin
            commit.dest      <= head_entry.dest;
            commit.funct3    <= head_entry.funct3;
            commit.value     <= head_entry.value;
            commit.addr      <= head_entry.addr;
            commit.reg_write <= head_entry.reg_write;
            commit.mem_write <= head_entry.mem_write;
        end
        if (flush) begin
            epc       <= head_entry.pc;
            exc_cause <= head_entry.cause;
        end

        if (rst) begin
            head_ptr     <= '0;
            commit.valid <= 1'b0;
            exc_valid    <= 1'b0;
            mret_valid   <= 1'b0;
        end else begin
            commit.valid <= (act == ACT_COMMIT);
            exc_valid    <= flush;
            mret_valid   <= (act == ACT_MRET);
            if (flush) begin
                head_ptr <= '0;  // Restart in step with the storage tail
            end else if (retire) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({exc_valid, mret_valid, commit.valid}))
        else $error("rob_retire: more than one retire event in a cycle");

endmodule

`default_nettype wire

/* source/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module rob_top import rob_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire dispatch_t          disp,
    input  wire wb_t                alu_wb,
    input  wire wb_t                mul_wb,
    input  wire wb_t                div_wb,
    input  wire lsu_wb_t            lsu_wb,
    input  wire br_t                br,
    output logic [`ROB_TAG_W-1:0]   disp_tag,
    output logic                    full,
    output commit_t                 commit,
    output logic                    exc_valid,
    output logic [`XLEN-1:0]        epc,
    output exc_cause_e              exc_cause,
    output logic                    mret_valid
);

    logic [`ROB_TAG_W:0] head_ptr;
    logic                retire;
    logic                flush;
    rob_entry_t          head_entry;

    rob_storage u_storage (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .alu_wb     (alu_wb),
        .mul_wb     (mul_wb),
        .div_wb     (div_wb),
        .lsu_wb     (lsu_wb),
        .br         (br),
        .head_ptr   (head_ptr),
        .retire     (retire),
        .flush      (flush),
        .disp_tag   (disp_tag),
        .full       (full),
        .head_entry (head_entry)
    );

    rob_retire u_retire (
        .clk        (clk),
        .rst        (rst),
        .head_entry (head_entry),
        .head_ptr   (head_ptr),
        .retire     (retire),
        .flush      (flush),
        .commit     (commit),
        .exc_valid  (exc_valid),
        .epc        (epc),
        .exc_cause  (exc_cause),
        .mret_valid (mret_valid)
    );

endmodule

`default_nettype wire

/* sim/tb_rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module tb_rob_top import rob_pkg::*; ();

    // One dispatched instruction as the reference model sees it
    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      value;
        logic [`XLEN-1:0]      addr;
        logic [4:0]            dest;
        logic [2:0]            funct3;
        logic                  reg_write;
        logic                  mem_write;
        logic                  is_mret;
        logic                  fault;
        exc_cause_e            cause;
    } exp_rec_t;

    logic                  clk;
    logic                  rst;
    dispatch_t             disp;
    wb_t                   alu_wb;
    wb_t                   mul_wb;
    wb_t                   div_wb;
    lsu_wb_t               lsu_wb;
    br_t                   br;
    logic [`ROB_TAG_W-1:0] disp_tag;
    logic                  full;
    commit_t               commit;
    logic                  exc_valid;
    logic [`XLEN-1:0]      epc;
    exc_cause_e            exc_cause;
    logic                  mret_valid;

    exp_rec_t         exp_q [$];  // Oldest first
    exp_rec_t         front;
    logic             have_front;
    logic [`XLEN-1:0] next_pc;
    int               errors;
    int               tests_passed;
    int               tests_failed;

    rob_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
        errors++;
    endtask

    task automatic event_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic sync_front();
        have_front = (exp_q.size() != 0);
        front      = have_front ? exp_q[0] : '0;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_ports();
        alu_wb = '0;
        mul_wb = '0;
        div_wb = '0;
        lsu_wb = '0;
        br     = '0;
    endtask

    function automatic int find_tag(input logic [`ROB_TAG_W-1:0] tag);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].tag == tag) begin
                return i;
            end
        end
        return -1;  // Squashed or flushed
    endfunction

    // Retire events consume the reference queue
    always @(posedge clk) begin
        if (!rst) begin
            if (exc_valid) begin
                exp_q.delete();  // Trap empties the buffer
            end else if ((commit.valid || mret_valid) && (exp_q.size() != 0)) begin
                void'(exp_q.pop_front());
            end
            sync_front();
        end
    end

    assert property (@(negedge clk) disable iff (rst)
        commit.valid |-> (have_front && !front.fault && !front.is_mret))
        else event_error("commit while no plain instruction was due at the head");
    assert property (@(negedge clk) disable iff (rst)
        exc_valid |-> (have_front && front.fault))
        else event_error("exception while no faulting entry was due at the head");
    assert property (@(negedge clk) disable iff (rst)
        mret_valid |-> (have_front && front.is_mret && !front.fault))
        else event_error("mret pulse while no mret was due at the head");
    assert property (@(negedge clk) disable iff (rst)
        commit.valid |-> (commit.dest == front.dest))
        else value_error("commit.dest", 32'(commit.dest), 32'(front.dest));
    assert property (@(negedge clk) disable iff (rst)
        commit.valid |-> (commit.funct3 == front.funct3))
        else value_error("commit.funct3", 32'(commit.funct3), 32'(front.funct3));
    assert property (@(negedge clk) disable iff (rst)
        commit.valid |-> (commit.value == front.value))
        else value_error("commit.value", commit.value, front.value);
    assert property (@(negedge clk) disable iff (rst)
        commit.valid |-> (commit.reg_write == front.reg_write))
        else value_error("commit.reg_write", 32'(commit.reg_write), 32'(front.reg_write));
    assert property (@(negedge clk) disable iff (rst)
        commit.valid |-> (commit.mem_write == front.mem_write))
        else value_error("commit.mem_write", 32'(commit.mem_write), 32'(front.mem_write));
    assert property (@(negedge clk) disable iff (rst)
        (commit.valid && front.mem_write) |-> (commit.addr == front.addr))
        else value_error("commit.addr", commit.addr, front.addr);
    assert property (@(negedge clk) disable iff (rst)
        exc_valid |-> (epc == front.pc))
        else value_error("epc", epc, front.pc);
    assert property (@(negedge clk) disable iff (rst)
        exc_valid |-> (exc_cause == front.cause))
        else value_error("exc_cause", 32'(exc_cause), 32'(front.cause));

    task automatic dispatch(input logic mem_write, input logic is_mret, input logic dec_fault,
                            output logic [`ROB_TAG_W-1:0] tag);
        exp_rec_t rec;
        int       n;
        n = 0;
        while (full && (n < 50)) begin
            step();
            n++;
        end
        if (full) begin
            event_error("timeout waiting for full to fall before a dispatch");
        end
        rec           = '0;
        rec.tag       = disp_tag;
        rec.pc        = next_pc;
        rec.value     = $urandom;
        rec.addr      = $urandom;
        rec.dest      = 5'($urandom);
        rec.funct3    = 3'($urandom);
        rec.reg_write = !mem_write && !is_mret;
        rec.mem_write = mem_write;
        rec.is_mret   = is_mret;
        rec.fault     = dec_fault;
        rec.cause     = CAUSE_DECODE;
        disp           = '0;
        disp.valid     = 1'b1;
        disp.pc        = rec.pc;
        disp.dest      = rec.dest;
        disp.funct3    = rec.funct3;
        disp.reg_write = rec.reg_write;
        disp.mem_write = mem_write;
        disp.is_mret   = is_mret;
        disp.dec_fault = dec_fault;
        exp_q.push_back(rec);
        sync_front();
        tag     = rec.tag;
        next_pc = next_pc + 32'd4;
        step();
        disp = '0;
    endtask

    // Port 0 ALU, 1 MUL, 2 DIV, 3 LSU; stores always go through the LSU
    task automatic complete(input logic [`ROB_TAG_W-1:0] tag, input int port,
                            input logic fault, input exc_cause_e cause);
        exp_rec_t rec;
        wb_t      wb;
        int       i;
        int       sel;
        i        = find_tag(tag);
        sel      = port;
        wb       = '0;
        wb.valid = 1'b1;
        wb.tag   = tag;
        wb.fault = fault;
        wb.cause = cause;
        wb.value = $urandom;  // Stale tag, value is never seen
        if (i >= 0) begin
            rec      = exp_q[i];
            wb.value = rec.value;
            if (fault) begin
                rec.fault = 1'b1;
                rec.cause = cause;
            end
            if (rec.mem_write) begin
                sel = 3;
            end
            lsu_wb.addr = rec.addr;
            exp_q[i]    = rec;
        end
        case (sel)
            0:       alu_wb    = wb;
            1:       mul_wb    = wb;
            2:       div_wb    = wb;
            default: lsu_wb.wb = wb;
        endcase
        sync_front();
        step();
        clear_ports();
    endtask

    task automatic resolve_branch(input logic [`ROB_TAG_W-1:0] tag, input logic mispredict);
        int i;
        i             = find_tag(tag);
        br.valid      = 1'b1;
        br.tag        = tag;
        br.mispredict = mispredict;
        br.link       = (i >= 0) ? exp_q[i].value : '0;
        if (mispredict && (i >= 0)) begin
            while (exp_q.size() > i + 1) begin
                void'(exp_q.pop_back());  // Wrong path never retires
            end
        end
        sync_front();
        step();
        clear_ports();
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < limit)) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            event_error("timeout waiting for outstanding entries to retire");
            exp_q.delete();
            sync_front();
        end
        repeat (4) step();  // Room for a stray retire to show up
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        logic [`ROB_TAG_W-1:0] tag;
        logic [`ROB_TAG_W-1:0] br_tag;
        logic [`ROB_TAG_W-1:0] tmp;
        logic [`ROB_TAG_W-1:0] tags [$];
        int                    e0;
        int                    j;
        void'($urandom(32'h5f9f));
        rst          = 1'b1;
        disp         = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        next_pc      = 32'h0000_1000;
        clear_ports();
        sync_front();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        e0 = errors;
        for (int k = 0; k < 8; k++) begin
            dispatch((k % 3) == 2, 1'b0, 1'b0, tag);
            tags.push_back(tag);
        end
        for (int k = tags.size() - 1; k > 0; k--) begin
            j       = int'($urandom % (k + 1));
            tmp     = tags[k];
            tags[k] = tags[j];
            tags[j] = tmp;
        end
        foreach (tags[k]) complete(tags[k], int'($urandom % 4), 1'b0, CAUSE_DECODE);
        wait_drain(40);
        end_test("in_order_retire", e0);

        e0 = errors;
        tags.delete();
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            dispatch(1'b0, 1'b0, 1'b0, tag);
            tags.push_back(tag);
        end
        assert (full) else event_error("full did not rise with every entry in use");
        tmp            = disp_tag;
        disp.valid     = 1'b1;  // Held while full, must be ignored
        disp.pc        = 32'h0bad_0000;
        disp.reg_write = 1'b1;
        repeat (3) step();
        assert (full && (disp_tag == tmp)) else event_error("dispatch accepted while full");
        disp = '0;
        complete(tags[0], 0, 1'b0, CAUSE_DECODE);
        j = 0;
        while (full && (j < 20)) begin
            step();
            j++;
        end
        assert (!full) else event_error("timeout waiting for full to fall after a retire");
        for (int k = 1; k < tags.size(); k++) begin
            complete(tags[k], int'($urandom % 4), 1'b0, CAUSE_DECODE);
        end
        wait_drain(60);
        end_test("full_backpressure", e0);

        e0 = errors;
        for (int c = 0; c < 3; c++) begin  // Decode, divide and memory fault on entry 1
            tags.delete();
            for (int k = 0; k < 4; k++) begin
                dispatch(1'b0, 1'b0, (c == 0) && (k == 1), tag);
                tags.push_back(tag);
            end
            complete(tags[3], 1, 1'b0, CAUSE_DECODE);
            complete(tags[2], 0, 1'b0, CAUSE_DECODE);
            complete(tags[0], 1, 1'b0, CAUSE_DECODE);
            if (c == 1) complete(tags[1], 2, 1'b1, CAUSE_DIV);
            if (c == 2) complete(tags[1], 3, 1'b1, CAUSE_LOAD_STORE);
            wait_drain(20);
            assert (disp_tag == '0) else value_error("disp_tag", 32'(disp_tag), 32'd0);
        end
        end_test("faults", e0);

        e0 = errors;
        tags.delete();
        dispatch(1'b0, 1'b0, 1'b0, br_tag);
        for (int k = 0; k < 3; k++) begin
            dispatch(1'b0, 1'b0, 1'b0, tag);
            tags.push_back(tag);
        end
        resolve_branch(br_tag, 1'b1);
        foreach (tags[k]) complete(tags[k], k, 1'b0, CAUSE_DECODE);  // Late, must be dropped
        tmp = `ROB_TAG_W'(br_tag + 1);
        dispatch(1'b0, 1'b0, 1'b0, tag);
        assert (tag == tmp) else value_error("disp_tag", 32'(tag), 32'(tmp));
        complete(tag, 0, 1'b0, CAUSE_DECODE);
        wait_drain(20);
        end_test("mispredict", e0);

        e0 = errors;
        tags.delete();
        dispatch(1'b0, 1'b1, 1'b0, tag);
        tags.push_back(tag);
        for (int k = 0; k < 2; k++) begin
            dispatch(1'b0, 1'b0, 1'b0, tag);
            tags.push_back(tag);
        end
        complete(tags[2], 1, 1'b0, CAUSE_DECODE);
        complete(tags[1], 2, 1'b0, CAUSE_DECODE);
        complete(tags[0], 0, 1'b0, CAUSE_DECODE);
        wait_drain(20);
        end_test("mret", e0);

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if ((errors == 0) && (tests_failed == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+source
source/rob_pkg.sv
source/rob_storage.sv
source/rob_retire.sv
source/rob_top.sv
sim/tb_rob_top.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_rob_top
RTL_TOP   ?= rob_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Everything OK

SIM := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the simulation prints the pass line
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
